//--- design/exec_unit.sv
/*
 * Single-cycle execute unit
 * Sixteen 32-bit registers, NZCV flags and the ALU. Sequencer words take
 * priority over decoder words; results land on the edge ending the cycle
 */
module exec_unit (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 dec_valid,
    input  logic [ucode_pkg::INSTR_W-1:0]        dec_instr,
    input  logic                                 seq_active,
    input  logic [ucode_pkg::INSTR_W-1:0]        seq_instr,
    input  logic [ucode_pkg::REG_ADDR_W-1:0]     rs2_addr,
    output logic [ucode_pkg::DATA_W-1:0]         rs2_data,
    input  logic                                 flags_restore,
    input  logic [3:0]                           flags_saved,
    output logic [3:0]                           flags,
    input  logic [ucode_pkg::REG_ADDR_W-1:0]     dbg_addr,
    output logic [ucode_pkg::DATA_W-1:0]         dbg_data
);
    import ucode_pkg::*;

    localparam int NUM_REGS = 1 << REG_ADDR_W;

    logic [DATA_W-1:0]     regs [NUM_REGS];
    logic                  ex_valid;
    logic [INSTR_W-1:0]    ex_instr;
    logic [OPC_W-1:0]      opcode;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [IMM_W-1:0]      imm;
    logic [DATA_W-1:0]     op_a;
    logic [DATA_W-1:0]     op_b;
    logic [DATA_W-1:0]     imm_ext;
    logic [DATA_W:0]       sum_ext;   // Carry in the top bit
    logic [DATA_W-1:0]     result;
    logic                  wr_en;
    logic                  flags_en;
    logic [3:0]            flags_new;

    // Source select, sequencer wins
    assign ex_valid = seq_active | dec_valid;
    assign ex_instr = seq_active ? seq_instr : dec_instr;

    assign opcode  = ex_instr[OPC_HI:OPC_LO];
    assign rd      = ex_instr[RD_LO +: REG_ADDR_W];
    assign rs1     = ex_instr[RS1_LO +: REG_ADDR_W];
    assign rs2     = ex_instr[RS2_LO +: REG_ADDR_W];
    assign imm     = ex_instr[IMM_LO +: IMM_W];
    assign imm_ext = {{(DATA_W - IMM_W){1'b0}}, imm};

    assign op_a    = regs[rs1];
    assign op_b    = regs[rs2];
    assign sum_ext = {1'b0, op_a} + {1'b0, op_b};

    // Combinational reads
    assign rs2_data = regs[rs2_addr];  // Count for MULR
    assign dbg_data = regs[dbg_addr];

    // ALU
    always_comb begin
        result   = sum_ext[DATA_W-1:0];
        wr_en    = 1'b0;
        flags_en = 1'b0;
        case (opcode)
            OP_MOV: begin
                result = imm_ext;
                wr_en  = ex_valid;
            end
            OP_ADD:  wr_en = ex_valid;
            OP_ADDS: begin
                wr_en    = ex_valid;
                flags_en = ex_valid;
            end
            OP_SUB: begin
                result = op_a - op_b;
                wr_en  = ex_valid;
            end
            OP_SUBI: begin
                result = op_a - imm_ext;
                wr_en  = ex_valid;
            end
            OP_NOT: begin
                result = ~op_a;
                wr_en  = ex_valid;
            end
            default: wr_en = 1'b0;  // NOP and unknown opcodes
        endcase
    end

    // NZCV of the add
    assign flags_new = {result[DATA_W-1],
                        result == '0,
                        sum_ext[DATA_W],
                        (op_a[DATA_W-1] == op_b[DATA_W-1]) &&
                        (result[DATA_W-1] != op_a[DATA_W-1])};

    // Register file
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd] <= result;
        end
    end

    // Flags, restore beats an ADDS
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags <= '0;
        end else if (flags_restore) begin
            flags <= flags_saved;
        end else if (flags_en) begin
            flags <= flags_new;
        end
    end

endmodule

//--- design/instr_decode.sv
/*
 * Instruction decoder
 * Takes instructions on a valid/ready port, forwards plain ones to the
 * execute unit and hands multiplies to the microcode sequencer
 */
module instr_decode (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 in_valid,
    input  logic [ucode_pkg::INSTR_W-1:0]        in_instr,
    output logic                                 in_ready,
    output logic                                 dec_valid,
    output logic [ucode_pkg::INSTR_W-1:0]        dec_instr,
    output logic                                 mul_start,
    output ucode_pkg::mul_kind_t                 mul_kind,
    output logic [ucode_pkg::REG_ADDR_W-1:0]     mul_rd,
    output logic [ucode_pkg::REG_ADDR_W-1:0]     mul_rs1,
    output logic [ucode_pkg::REG_ADDR_W-1:0]     mul_rs2,
    output logic [ucode_pkg::IMM_W-1:0]          mul_imm,
    input  logic                                 mul_release
);
    import ucode_pkg::*;

    logic [OPC_W-1:0] opcode;
    logic             is_mul;    // Opcode is one of the multiplies
    mul_kind_t        kind_dec;
    logic             accept;    // Transfer on this edge
    logic             busy;      // Multiply in flight
    logic             run_q;     // Out of reset

    assign opcode   = in_instr[OPC_HI:OPC_LO];
    assign accept   = in_valid & in_ready;
    assign in_ready = run_q & ~busy;  // Low in reset and while a multiply runs

    // Classify by opcode
    always_comb begin
        is_mul   = 1'b1;
        kind_dec = MUL_IMM;
        case (opcode)
            OP_MULI:  kind_dec = MUL_IMM;
            OP_MULR:  kind_dec = MUL_REG;
            OP_MULSI: kind_dec = MUL_SIMM;
            default:  is_mul = 1'b0;  // Plain or NOP, goes to execute
        endcase
    end

    // Control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_q     <= 1'b0;
            busy      <= 1'b0;
            dec_valid <= 1'b0;
            mul_start <= 1'b0;
        end else begin
            run_q     <= 1'b1;
            dec_valid <= accept & ~is_mul;  // One cycle per plain instruction
            mul_start <= accept & is_mul;   // One cycle kick for the sequencer
            if (accept && is_mul) begin
                busy <= 1'b1;
            end else if (mul_release) begin
                busy <= 1'b0;  // Ready again the cycle after release
            end
        end
    end

    // Payload, captured on accept
    always_ff @(posedge clk) begin
        if (accept && !is_mul) begin
            dec_instr <= in_instr;
        end
        if (accept && is_mul) begin
            mul_kind <= kind_dec;
            mul_rd   <= in_instr[RD_LO +: REG_ADDR_W];
            mul_rs1  <= in_instr[RS1_LO +: REG_ADDR_W];
            mul_rs2  <= in_instr[RS2_LO +: REG_ADDR_W];  // Count register for MULR
            mul_imm  <= in_instr[IMM_LO +: IMM_W];
        end
    end

endmodule

//--- design/mul_subsystem.sv
/*
 * Multiply execution slice top level
 * Decoder, microcode sequencer and execute unit with a debug read port
 */
module mul_subsystem (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 in_valid,
    input  logic [ucode_pkg::INSTR_W-1:0]        in_instr,
    output logic                                 in_ready,
    input  logic [ucode_pkg::REG_ADDR_W-1:0]     dbg_addr,
    output logic [ucode_pkg::DATA_W-1:0]         dbg_data,
    output logic [3:0]                           flags
);
    import ucode_pkg::*;

    // Decoder to execute
    logic                  dec_valid;
    logic [INSTR_W-1:0]    dec_instr;

    // Decoder to sequencer
    logic                  mul_start;
    mul_kind_t             mul_kind;
    logic [REG_ADDR_W-1:0] mul_rd;
    logic [REG_ADDR_W-1:0] mul_rs1;
    logic [REG_ADDR_W-1:0] mul_rs2;  // Also the execute read address
    logic [IMM_W-1:0]      mul_imm;
    logic                  mul_release;

    // Sequencer and execute
    logic                  seq_active;
    logic [INSTR_W-1:0]    seq_instr;
    logic [DATA_W-1:0]     rs2_data;
    logic                  flags_restore;
    logic [3:0]            flags_saved;

    instr_decode instr_decode_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .in_ready    (in_ready),
        .dec_valid   (dec_valid),
        .dec_instr   (dec_instr),
        .mul_start   (mul_start),
        .mul_kind    (mul_kind),
        .mul_rd      (mul_rd),
        .mul_rs1     (mul_rs1),
        .mul_rs2     (mul_rs2),
        .mul_imm     (mul_imm),
        .mul_release (mul_release)
    );

    ucode_sequencer ucode_sequencer_i (
        .clk           (clk),
        .rst           (rst),
        .mul_start     (mul_start),
        .mul_kind      (mul_kind),
        .mul_rd        (mul_rd),
        .mul_rs1       (mul_rs1),
        .mul_imm       (mul_imm),
        .rs2_data      (rs2_data),
        .flags         (flags),
        .seq_active    (seq_active),
        .seq_instr     (seq_instr),
        .flags_restore (flags_restore),
        .flags_saved   (flags_saved),
        .mul_release   (mul_release)
    );

    exec_unit exec_unit_i (
        .clk           (clk),
        .rst           (rst),
        .dec_valid     (dec_valid),
        .dec_instr     (dec_instr),
        .seq_active    (seq_active),
        .seq_instr     (seq_instr),
        .rs2_addr      (mul_rs2),
        .rs2_data      (rs2_data),
        .flags_restore (flags_restore),
        .flags_saved   (flags_saved),
        .flags         (flags),
        .dbg_addr      (dbg_addr),
        .dbg_data      (dbg_data)
    );

endmodule

//--- design/ucode_pkg.sv
/*
 * Multiply microcode slice shared definitions
 * Opcodes, instruction field positions, the NOP word and the multiply kinds
 * used by the decoder, the sequencer and the execute unit
 */
package ucode_pkg;

    // Sizes
    localparam int REG_ADDR_W = 4;   // Sixteen registers
    localparam int DATA_W     = 32;  // Register width
    localparam int INSTR_W    = 32;  // Instruction word width
    localparam int IMM_W      = 16;  // Immediate field width

    // Field positions
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 25;
    localparam int OPC_W  = OPC_HI - OPC_LO + 1;
    localparam int RD_LO  = 21;  // Destination at 24..21
    localparam int RS1_LO = 17;  // First source at 20..17
    localparam int RS2_LO = 13;  // Second source at 16..13
    localparam int IMM_LO = 0;   // Immediate at 15..0, overlaps RS2

    // Plain register instructions
    localparam logic [OPC_W-1:0] OP_MOV   = 7'b0000000;  // rd = zext(imm)
    localparam logic [OPC_W-1:0] OP_ADD   = 7'b0110001;  // rd = rs1 + rs2
    localparam logic [OPC_W-1:0] OP_SUB   = 7'b0110010;  // rd = rs1 - rs2
    localparam logic [OPC_W-1:0] OP_SUBI  = 7'b0010010;  // rd = rs1 - zext(imm)
    localparam logic [OPC_W-1:0] OP_ADDS  = 7'b0111001;  // ADD and update NZCV
    localparam logic [OPC_W-1:0] OP_NOT   = 7'b0110110;  // rd = ~rs1

    // Multiplies, expanded by the sequencer
    localparam logic [OPC_W-1:0] OP_MULI  = 7'b1000001;  // rd = rs1 * imm
    localparam logic [OPC_W-1:0] OP_MULR  = 7'b1000010;  // rd = rs1 * rs2[15:0]
    localparam logic [OPC_W-1:0] OP_MULSI = 7'b1000011;  // rd = rs1 * signed imm

    // No operation, fixed prefix then zeros
    localparam logic [INSTR_W-1:0] NOP_WORD = {5'b11001, 27'b0};

    // Multiply flavour handed from decoder to sequencer
    typedef enum logic [1:0] {
        MUL_IMM  = 2'd0,  // Unsigned immediate count
        MUL_REG  = 2'd1,  // Count from low half of rs2
        MUL_SIMM = 2'd2   // Signed immediate count
    } mul_kind_t;

endpackage

//--- design/ucode_sequencer.sv
/*
 * Multiply microcode sequencer
 * Expands MULI, MULR and MULSI into MOV, ADD or ADDS, and a SUBI/NOT
 * negation pair, injected into the execute unit. Saves the flags at start
 * and restores them on release
 */
module ucode_sequencer (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 mul_start,
    input  ucode_pkg::mul_kind_t                 mul_kind,
    input  logic [ucode_pkg::REG_ADDR_W-1:0]     mul_rd,
    input  logic [ucode_pkg::REG_ADDR_W-1:0]     mul_rs1,
    input  logic [ucode_pkg::IMM_W-1:0]          mul_imm,
    input  logic [ucode_pkg::DATA_W-1:0]         rs2_data,
    input  logic [3:0]                           flags,
    output logic                                 seq_active,
    output logic [ucode_pkg::INSTR_W-1:0]        seq_instr,
    output logic                                 flags_restore,
    output logic [3:0]                           flags_saved,
    output logic                                 mul_release
);
    import ucode_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_CLEAR,    // Count zero, SUB rd,rd,rd
        S_MOVE,     // MOV rd,#0 before the adds
        S_ADD,      // One accumulate per count
        S_NEG_DEC,  // SUBI rd,rd,#1
        S_NEG_INV,  // NOT rd,rd
        S_RELEASE   // Hand the stream back
    } state_t;

    state_t                state, state_next;
    logic                  take;       // Start seen while idle
    logic [IMM_W-1:0]      start_cnt;  // Count as loaded at start
    logic [IMM_W-1:0]      cnt;        // Adds still to issue
    mul_kind_t             kind_q;
    logic                  neg_q;      // Negative MULSI, negate at the end
    logic [3:0]            flags_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic [REG_ADDR_W-1:0] rs1_q;
    logic [OPC_W-1:0]      add_op;

    assign take        = (state == S_IDLE) && mul_start;
    assign add_op      = (kind_q == MUL_SIMM) ? OP_ADDS : OP_ADD;
    assign flags_saved = flags_q;

    // Count source per kind
    always_comb begin
        case (mul_kind)
            MUL_REG:  start_cnt = rs2_data[IMM_W-1:0];
            MUL_SIMM: start_cnt = mul_imm[IMM_W-1] ? -mul_imm : mul_imm;  // Magnitude
            default:  start_cnt = mul_imm;
        endcase
    end

    // Next state and the injected word
    always_comb begin
        state_next    = state;
        seq_active    = 1'b0;
        seq_instr     = NOP_WORD;
        mul_release   = 1'b0;
        flags_restore = 1'b0;
        case (state)
            S_IDLE: begin
                if (mul_start) begin
                    state_next = (start_cnt == '0) ? S_CLEAR : S_MOVE;
                end
            end
            S_CLEAR: begin
                seq_active = 1'b1;
                seq_instr  = {OP_SUB, rd_q, rd_q, rd_q, {RS2_LO{1'b0}}};
                state_next = S_RELEASE;
            end
            S_MOVE: begin
                seq_active = 1'b1;
                seq_instr  = {OP_MOV, rd_q, 5'b0, {IMM_W{1'b0}}};  // Zero the accumulator
                state_next = S_ADD;
            end
            S_ADD: begin
                seq_active = 1'b1;
                seq_instr  = {add_op, rd_q, rd_q, rs1_q, {RS2_LO{1'b0}}};
                if (cnt == 16'd1) begin  // Last add
                    state_next = neg_q ? S_NEG_DEC : S_RELEASE;
                end
            end
            S_NEG_DEC: begin
                // Two's complement as ~(x - 1)
                seq_active = 1'b1;
                seq_instr  = {OP_SUBI, rd_q, rd_q, 1'b0, 16'd1};
                state_next = S_NEG_INV;
            end
            S_NEG_INV: begin
                seq_active = 1'b1;
                seq_instr  = {OP_NOT, rd_q, rd_q, 17'b0};
                state_next = S_RELEASE;
            end
            S_RELEASE: begin
                mul_release   = 1'b1;
                flags_restore = 1'b1;  // Put back pre-multiply NZCV
                state_next    = S_IDLE;
            end
            default: state_next = S_IDLE;
        endcase
    end

    // Control state, counter and saved flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= S_IDLE;
            cnt     <= '0;
            kind_q  <= MUL_IMM;
            neg_q   <= 1'b0;
            flags_q <= '0;
        end else begin
            state <= state_next;
            if (take) begin
                cnt     <= start_cnt;
                kind_q  <= mul_kind;
                neg_q   <= (mul_kind == MUL_SIMM) && mul_imm[IMM_W-1];
                flags_q <= flags;  // Flags left by the last plain instruction
            end else if (state == S_ADD) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // Register numbers for the injected words
    always_ff @(posedge clk) begin
        if (take) begin
            rd_q  <= mul_rd;
            rs1_q <= mul_rs1;
        end
    end

endmodule

//--- files.f
design/ucode_pkg.sv
design/instr_decode.sv
design/ucode_sequencer.sv
design/exec_unit.sv
design/mul_subsystem.sv
test/mul_subsystem_sva.sv
test/tb_mul_subsystem.sv

//--- test/mul_subsystem_sva.sv
/*
 * Sequencer release assertions
 * Release is a one-cycle pulse with no injection and carries the flag restore
 */
module mul_subsystem_sva (
    input logic clk,
    input logic rst,
    input logic mul_release,
    input logic seq_active,
    input logic flags_restore
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;  // Failed assertion count

    release_pulse: assert property (@(posedge clk) disable iff (rst)
        mul_release |=> !mul_release)               // Single cycle only
        else begin
            failures++;
            $error("mul_release stayed high for more than one cycle");
        end

    // Nothing injected while the stream is handed back
    release_idle: assert property (@(posedge clk) disable iff (rst)
        mul_release |-> !seq_active)
        else begin
            failures++;
            $error("seq_active high in the release cycle");
        end

    restore_with_release: assert property (@(posedge clk) disable iff (rst)
        flags_restore == mul_release)
        else begin
            failures++;
            $error("flags_restore and mul_release out of step");
        end

endmodule

bind ucode_sequencer mul_subsystem_sva mul_subsystem_sva_i (
    .clk           (clk),
    .rst           (rst),
    .mul_release   (mul_release),
    .seq_active    (seq_active),
    .flags_restore (flags_restore)
);

//--- test/tb_mul_subsystem.sv
/*
 * Testbench for the multiply execution slice
 * Runs a plain ALU burst and a table of MULI, MULR and MULSI programs,
 * checking registers, restored flags and the stall on in_ready
 */
module tb_mul_subsystem;
    timeunit 1ns;
    timeprecision 100ps;
    import ucode_pkg::*;

    localparam int NUM_TESTS = 10;
    localparam int TIMEOUT   = 1000;           // Cycles allowed per wait
    localparam logic [3:0] CNT_REG = 4'd10;    // Count register for MULR
    localparam logic [3:0] FA_REG  = 4'd11;    // ADDS operands and sum
    localparam logic [3:0] FB_REG  = 4'd12;
    localparam logic [3:0] FS_REG  = 4'd13;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [31:0] in_instr;
    logic        in_ready;
    logic [3:0]  dbg_addr;
    logic [31:0] dbg_data;
    logic [3:0]  flags;

    // Stimulus and expected values, one row per multiply
    string       t_name [NUM_TESTS];
    logic [31:0] t_src  [NUM_TESTS];
    logic [15:0] t_cnt  [NUM_TESTS];
    mul_kind_t   t_kind [NUM_TESTS];
    logic [3:0]  t_rd   [NUM_TESTS];
    logic [3:0]  t_rs1  [NUM_TESTS];
    logic [31:0] t_exp  [NUM_TESTS];

    // ADDS operand pairs run just before each multiply, upper half 0 or all ones
    logic [31:0] adds_a [4] = '{32'hFFFF8000, 32'hFFFF0001, 32'h00007FFF, 32'hFFFF0000};
    logic [31:0] adds_b [4] = '{32'h00008000, 32'h00000001, 32'h00000001, 32'hFFFF0000};

    int     errors;
    int     tests;
    int     stalls;    // First-look in_ready lows seen by send_instr
    bit     aborted;   // Set by a timeout, later steps are skipped
    integer seed;

    mul_subsystem mul_subsystem_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .in_ready (in_ready),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data),
        .flags    (flags)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    function automatic logic [31:0] enc_reg(input logic [6:0] op, input logic [3:0] rd,
                                            input logic [3:0] rs1, input logic [3:0] rs2);
        return {op, rd, rs1, rs2, 13'b0};
    endfunction

    function automatic logic [31:0] enc_imm(input logic [6:0] op, input logic [3:0] rd,
                                            input logic [3:0] rs1, input logic [15:0] imm);
        return {op, rd, rs1, 1'b0, imm};
    endfunction

    // Product modulo 2^32, negated when a signed count is negative
    function automatic logic [31:0] mul_expect(input logic [31:0] src, input logic [15:0] cnt,
                                               input mul_kind_t kind);
        logic        neg;
        logic [15:0] mag;
        logic [31:0] prod;
        neg  = (kind == MUL_SIMM) && cnt[15];
        mag  = neg ? 16'd0 - cnt : cnt;
        prod = src * {16'd0, mag};
        return neg ? 32'd0 - prod : prod;
    endfunction

    // NZCV of a 32-bit add
    function automatic logic [3:0] adds_flags(input logic [31:0] a, input logic [31:0] b);
        logic [32:0] sum;
        logic [32:0] ssum;  // Sign-extended sum for overflow
        sum  = {1'b0, a} + {1'b0, b};
        ssum = {a[31], a} + {b[31], b};
        return {sum[31], sum[31:0] == 32'd0, sum[32], ssum[32] != ssum[31]};
    endfunction

    function automatic void set_row(input int i, input string name, input logic [31:0] src,
                                    input logic [15:0] cnt, input mul_kind_t kind,
                                    input logic [3:0] rd, input logic [3:0] rs1);
        t_name[i] = name;
        t_src[i]  = src;
        t_cnt[i]  = cnt;
        t_kind[i] = kind;
        t_rd[i]   = rd;
        t_rs1[i]  = rs1;
        t_exp[i]  = mul_expect(src, cnt, kind);
    endfunction

    // Random value that MOV or MOV plus NOT can build
    function automatic logic [31:0] loadable_random();
        logic [31:0] r;
        r = $random(seed);
        return r[31] ? {16'hFFFF, r[15:0]} : {16'h0000, r[15:0]};
    endfunction

    // Present one word and hold it until the transfer edge
    task automatic send_instr(input logic [31:0] w);
        int waited;
        if (!aborted) begin
            in_valid <= 1'b1;
            in_instr <= w;
            waited = 0;
            @(negedge clk);
            if (!in_ready) stalls++;
            while (!in_ready && waited < TIMEOUT) begin
                waited++;
                @(negedge clk);
            end
            if (!in_ready) begin
                $display("timeout: instruction %h was never accepted", w);
                errors++;
                aborted = 1'b1;
            end
            @(posedge clk);        // Transfer edge
            in_valid <= 1'b0;      // A following send overrides this
        end
    endtask

    // Poll in_ready at falling edges until it reaches the given level
    task automatic wait_ready(input logic level, input string what);
        int waited;
        if (!aborted) begin
            waited = 0;
            @(negedge clk);
            while (in_ready !== level && waited < TIMEOUT) begin
                waited++;
                @(negedge clk);
            end
            if (in_ready !== level) begin
                $display("timeout: in_ready did not %s during %s", level ? "rise" : "fall", what);
                errors++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic load_value(input logic [3:0] r, input logic [31:0] v);
        if (v[31:16] == 16'hFFFF) begin
            send_instr(enc_imm(OP_MOV, r, 4'd0, ~v[15:0]));
            send_instr(enc_reg(OP_NOT, r, r, 4'd0));   // Upper half becomes all ones
        end else begin
            send_instr(enc_imm(OP_MOV, r, 4'd0, v[15:0]));
        end
    endtask

    task automatic read_reg(input logic [3:0] r, output logic [31:0] v, output logic [3:0] f);
        dbg_addr <= r;
        @(negedge clk);
        v = dbg_data;   // Combinational read, stable mid-cycle
        f = flags;
        @(posedge clk);
    endtask

    task automatic run_alu_burst();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp_v [7];
        logic [31:0] got;
        logic [3:0]  f;
        int          stalls_before;
        int          bad;
        a = 32'h00009000;
        b = 32'h00001234;
        exp_v = '{32'd0, a, b, a + b, b - a, a - 32'h100, ~b};  // r0 is never written
        bad = 0;
        stalls_before = stalls;
        send_instr(enc_imm(OP_MOV, 4'd1, 4'd0, a[15:0]));
        send_instr(enc_imm(OP_MOV, 4'd2, 4'd0, b[15:0]));
        send_instr(enc_reg(OP_ADD, 4'd3, 4'd1, 4'd2));
        send_instr(enc_reg(OP_SUB, 4'd4, 4'd2, 4'd1));
        send_instr(enc_imm(OP_SUBI, 4'd5, 4'd1, 16'h0100));
        send_instr(NOP_WORD);                             // Must leave everything alone
        send_instr(enc_reg(OP_NOT, 4'd6, 4'd2, 4'd0));
        repeat (2) @(posedge clk);                        // Last write lands one cycle on
        if (!aborted) begin
            tests++;
            if (stalls != stalls_before) begin
                $display("alu_burst: in_ready dropped during plain instructions");
                errors++;
                bad++;
            end
            for (int r = 0; r <= 6; r++) begin
                read_reg(r[3:0], got, f);
                if (got !== exp_v[r]) begin
                    $display("mismatch alu_burst r%0d expected %h actual %h", r, exp_v[r], got);
                    errors++;
                    bad++;
                end
            end
            if (f !== 4'b0000) begin  // No ADDS yet, NZCV still at reset value
                $display("mismatch alu_burst flags expected %b actual %b", 4'b0000, f);
                errors++;
                bad++;
            end
            if (bad == 0) $display("ok   alu_burst");
        end
    endtask

    task automatic run_row(input int i);
        logic [31:0] fa;
        logic [31:0] fb;
        logic [3:0]  exp_f;
        logic [31:0] mul_word;
        logic [31:0] got;
        logic [3:0]  got_f;
        fa    = adds_a[i % 4];
        fb    = adds_b[i % 4];
        exp_f = adds_flags(fa, fb);
        case (t_kind[i])
            MUL_REG:  mul_word = enc_reg(OP_MULR, t_rd[i], t_rs1[i], CNT_REG);
            MUL_SIMM: mul_word = enc_imm(OP_MULSI, t_rd[i], t_rs1[i], t_cnt[i]);
            default:  mul_word = enc_imm(OP_MULI, t_rd[i], t_rs1[i], t_cnt[i]);
        endcase
        load_value(t_rs1[i], t_src[i]);
        send_instr(enc_imm(OP_MOV, t_rd[i], 4'd0, 16'hBEEF));   // Stale destination
        if (t_kind[i] == MUL_REG) begin
            load_value(CNT_REG, {16'hFFFF, t_cnt[i]});         // Only the low half counts
        end
        load_value(FA_REG, fa);
        load_value(FB_REG, fb);
        send_instr(enc_reg(OP_ADDS, FS_REG, FA_REG, FB_REG));  // Flags to survive the multiply
        send_instr(mul_word);
        wait_ready(1'b0, t_name[i]);   // Stall must show up
        wait_ready(1'b1, t_name[i]);   // Then the stream is released
        @(posedge clk);
        if (!aborted) begin
            tests++;
            read_reg(t_rd[i], got, got_f);
            if (got !== t_exp[i]) begin
                $display("mismatch %s expected %h actual %h", t_name[i], t_exp[i], got);
                errors++;
            end else if (got_f !== exp_f) begin
                $display("mismatch %s flags expected %b actual %b", t_name[i], exp_f, got_f);
                errors++;
            end else begin
                $display("ok   %s", t_name[i]);
            end
        end
    endtask

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_instr = NOP_WORD;
        dbg_addr = 4'd0;
        errors   = 0;
        tests    = 0;
        stalls   = 0;
        aborted  = 1'b0;
        seed     = 32'h08e676c8;

        set_row(0, "muli_zero",      32'h00001234,      16'd0,  MUL_IMM,  4'd1, 4'd2);
        set_row(1, "muli_one",       32'hFFFF8001,      16'd1,  MUL_IMM,  4'd3, 4'd4);
        set_row(2, "muli_seven",     32'h0000ABCD,      16'd7,  MUL_IMM,  4'd5, 4'd6);
        set_row(3, "muli_random",    loadable_random(), 16'($random(seed) & 31), MUL_IMM,
                4'd7, 4'd8);
        set_row(4, "mulr_five",      32'h00000321,      16'd5,  MUL_REG,  4'd9, 4'd1);
        set_row(5, "mulr_zero",      32'h00000077,      16'd0,  MUL_REG,  4'd2, 4'd3);
        set_row(6, "mulr_random",    loadable_random(), 16'($random(seed) & 31), MUL_REG,
                4'd4, 4'd5);
        set_row(7, "mulsi_positive", 32'h00001111,      16'd9,  MUL_SIMM, 4'd6, 4'd7);
        set_row(8, "mulsi_negative", 32'h00000123,      16'hFFFA, MUL_SIMM, 4'd8, 4'd9);
        set_row(9, "mulsi_random",   loadable_random(), 16'd0 - 16'(($random(seed) & 31) + 1),
                MUL_SIMM, 4'd1, 4'd9);

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        wait_ready(1'b1, "reset release");
        @(posedge clk);

        run_alu_burst();
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (!aborted) run_row(i);
        end

        if (mul_subsystem_i.ucode_sequencer_i.mul_subsystem_sva_i.failures != 0) begin
            $display("sequencer assertions failed %0d times",
                     mul_subsystem_i.ucode_sequencer_i.mul_subsystem_sva_i.failures);
            errors += mul_subsystem_i.ucode_sequencer_i.mul_subsystem_sva_i.failures;
        end

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
